// ==== compile.f ====
+incdir+rtl
rtl/cnn_pkg.sv
rtl/feature_link_if.sv
rtl/credit_fifo.sv
rtl/kernel_store.sv
rtl/conv1d_relu.sv
rtl/max_pool_pair.sv
rtl/cnn_layer_top.sv
tests/tb_cnn_layer.sv

// ==== tests/tb_cnn_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module tb_cnn_layer
    import cnn_pkg::*;
();

    localparam int ACT     = `CNN_ACT_BITS;
    localparam int NF      = `CNN_NUM_FILTERS;
    localparam int CREDITS = `CNN_LINK_CREDITS;
    localparam int FEAT_W  = NF * ACT;
    localparam int TIMEOUT = 2000;

    logic clk;
    logic rst_n;
    logic i_sample_valid;
    sample_t i_sample;
    logic i_sample_last;
    logic o_sample_credit;
    logic i_load_weights;
    weights_flat_t i_weights;
    logic i_load_biases;
    biases_flat_t i_biases;
    logic o_feat_valid;
    feature_vec_t o_feat;
    logic o_feat_last;
    logic i_feat_credit;

    // Reference copies of the loaded parameters and the current sequence
    weights_flat_t weights;
    biases_flat_t biases;
    sample_t seq [64];
    logic [FEAT_W:0] out_q [$];
    integer seed = 78;
    int sample_credits;
    int errors;
    int timeouts;
    int tests_run;
    logic slow_sink;
    int pending;
    int hold;
    int outstanding;

    cnn_layer_top dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_sample_valid  (i_sample_valid),
        .i_sample        (i_sample),
        .i_sample_last   (i_sample_last),
        .o_sample_credit (o_sample_credit),
        .i_load_weights  (i_load_weights),
        .i_weights       (i_weights),
        .i_load_biases   (i_load_biases),
        .i_biases        (i_biases),
        .o_feat_valid    (o_feat_valid),
        .o_feat          (o_feat),
        .o_feat_last     (o_feat_last),
        .i_feat_credit   (i_feat_credit)
    );

    always #50 clk = ~clk;

    // Output sink returning credits immediately or after a random hold
    always @(negedge clk) begin
        if (!rst_n) begin
            pending = 0;
            hold = 0;
            outstanding = 0;
            i_feat_credit = 1'b0;
        end else begin
            if (o_feat_valid) begin
                out_q.push_back({o_feat_last, o_feat});
                outstanding++;
                pending++;
                if (outstanding > CREDITS) begin
                    $display("DUT sent more outputs than the sink had credits for");
                    errors++;
                end
            end
            if (hold > 0) begin
                hold--;
                i_feat_credit = 1'b0;
            end else if (pending > 0) begin
                i_feat_credit = 1'b1;
                pending--;
                outstanding--;
                if (slow_sink) begin
                    hold = {$random(seed)} % 6;
                end
            end else begin
                i_feat_credit = 1'b0;
            end
        end
    end

    function automatic int conv_value(input int n, input int f, input int len);
        int acc;
        int pos;
        int x;
        acc = int'($signed(biases[f*ACT +: ACT]));
        for (int t = 0; t < 3; t++) begin
            pos = n - 1 + t;
            x = (pos < 0 || pos >= len) ? 0 : int'(seq[pos]);
            acc = acc + int'($signed(weights[(f*3+t)*ACT +: ACT])) * x;
        end
        if (acc < 0) begin
            return 0;
        end
        return (acc > 255) ? 255 : acc;
    endfunction

    function automatic feature_vec_t pooled_vec(input int k, input int len);
        feature_vec_t v;
        int a;
        int b;
        for (int f = 0; f < NF; f++) begin
            a = conv_value(2*k, f, len);
            // Lone final position pools with 0 as features are never negative
            b = (2*k + 1 < len) ? conv_value(2*k + 1, f, len) : 0;
            v[f*ACT +: ACT] = (a > b) ? a : b;
        end
        return v;
    endfunction

    task automatic load_params();
        @(negedge clk);
        i_weights = weights;
        i_biases = biases;
        i_load_weights = 1'b1;
        i_load_biases = 1'b1;
        @(negedge clk);
        i_load_weights = 1'b0;
        i_load_biases = 1'b0;
    endtask

    // Sends seq[0..len-1] under credit and waits for every credit to return
    task automatic send_samples(input string name, input int len);
        int idx;
        int cycles;
        idx = 0;
        cycles = 0;
        while ((idx < len || sample_credits < CREDITS) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (o_sample_credit) begin
                sample_credits++;
                if (sample_credits > CREDITS) begin
                    $display("%s: DUT returned more input credits than samples sent", name);
                    errors++;
                end
            end
            if (idx < len && sample_credits > 0) begin
                i_sample_valid = 1'b1;
                i_sample = seq[idx];
                i_sample_last = (idx == len - 1);
                sample_credits--;
                idx++;
            end else begin
                i_sample_valid = 1'b0;
                i_sample_last = 1'b0;
            end
        end
        i_sample_valid = 1'b0;
        if (cycles >= TIMEOUT) begin
            $display("Timeout in %s: input credits did not come back", name);
            timeouts++;
        end
    endtask

    task automatic wait_outputs(input string name, input int n);
        int cycles;
        cycles = 0;
        while (out_q.size() < n && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (out_q.size() < n) begin
            $display("Timeout in %s: got %0d of %0d outputs", name, out_q.size(), n);
            timeouts++;
        end
        @(posedge clk);
    endtask

    task automatic run_and_check(input string name, input int len);
        int n_out;
        feature_vec_t exp_v;
        logic exp_last;
        n_out = (len + 1) / 2;
        // Anything still queued arrived after the previous sequence closed
        if (out_q.size() != 0) begin
            $display("Error: %s stray outputs expected 0 actual %0d", name, out_q.size());
            errors++;
        end
        out_q.delete();
        send_samples(name, len);
        wait_outputs(name, n_out);
        if (out_q.size() != n_out) begin
            $display("Error: %s output count expected %0d actual %0d", name, n_out, out_q.size());
            errors++;
        end
        for (int k = 0; k < n_out && k < out_q.size(); k++) begin
            exp_v = pooled_vec(k, len);
            exp_last = (k == n_out - 1);
            if (out_q[k][FEAT_W-1:0] !== exp_v) begin
                $display("Error: %s output %0d expected %h actual %h",
                         name, k, exp_v, out_q[k][FEAT_W-1:0]);
                errors++;
            end
            if (out_q[k][FEAT_W] !== exp_last) begin
                $display("Error: %s output %0d last expected %0b actual %0b",
                         name, k, exp_last, out_q[k][FEAT_W]);
                errors++;
            end
        end
        while (out_q.size() > 0 && n_out > 0) begin
            out_q.delete(0);
            n_out--;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        $display("Test %s finished with %0d errors", name, errors - errs_before);
    endtask

    task automatic test_zero_weights();
        int errs;
        errs = errors;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (o_sample_credit) begin
                $display("zero_weights: input credit pulsed before any sample was sent");
                errors++;
            end
        end
        if (out_q.size() != 0) begin
            $display("Error: zero_weights idle outputs expected 0 actual %0d", out_q.size());
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            seq[i] = sample_t'(i * 17 + 5);
        end
        run_and_check("zero_weights", 8);
        report_test("zero_weights", errs);
    endtask

    task automatic test_identity_ramp();
        int errs;
        errs = errors;
        weights = '0;
        biases = '0;
        for (int f = 0; f < NF; f++) begin
            weights[(f*3+1)*ACT +: ACT] = 8'd1;
        end
        load_params();
        for (int i = 0; i < 8; i++) begin
            seq[i] = sample_t'(i * 30);
        end
        run_and_check("identity_ramp", 8);
        report_test("identity_ramp", errs);
    endtask

    task automatic test_edge_taps();
        int errs;
        errs = errors;
        weights = '0;
        biases = '0;
        for (int f = 0; f < NF; f++) begin
            weights[(f*3)*ACT +: ACT] = ACT'(f + 1);
            weights[(f*3+2)*ACT +: ACT] = 8'd2;
        end
        load_params();
        for (int i = 0; i < 5; i++) begin
            seq[i] = sample_t'((i + 1) * 9);
        end
        run_and_check("edge_taps", 5);
        report_test("edge_taps", errs);
    endtask

    task automatic test_relu_saturation();
        int errs;
        errs = errors;
        for (int f = 0; f < NF; f++) begin
            biases[f*ACT +: ACT] = 8'd127;
            for (int t = 0; t < 3; t++) begin
                // Low filters lean negative and high filters positive
                if (f < NF / 2) begin
                    weights[(f*3+t)*ACT +: ACT] = ACT'(-(1 + ({$random(seed)} % 64)));
                end else begin
                    weights[(f*3+t)*ACT +: ACT] = ACT'(1 + ({$random(seed)} % 64));
                end
            end
        end
        load_params();
        for (int i = 0; i < 10; i++) begin
            seq[i] = sample_t'($random(seed));
        end
        run_and_check("relu_saturation", 10);
        report_test("relu_saturation", errs);
    endtask

    task automatic test_slow_sink();
        int errs;
        errs = errors;
        weights = weights_flat_t'({$random(seed), $random(seed), $random(seed),
                                   $random(seed), $random(seed), $random(seed)});
        biases = biases_flat_t'({$random(seed), $random(seed)});
        load_params();
        for (int i = 0; i < 20; i++) begin
            seq[i] = sample_t'($random(seed));
        end
        slow_sink = 1'b1;
        run_and_check("slow_sink", 20);
        slow_sink = 1'b0;
        report_test("slow_sink", errs);
    endtask

    task automatic test_back_to_back();
        int errs;
        errs = errors;
        weights = '0;
        biases = '0;
        for (int f = 0; f < NF; f++) begin
            weights[(f*3+2)*ACT +: ACT] = 8'd1;
        end
        load_params();
        for (int i = 0; i < 6; i++) begin
            seq[i] = sample_t'(200 - i * 25);
        end
        run_and_check("back_to_back", 6);
        // Left tap catches a window left over from the first sequence
        weights = '0;
        for (int f = 0; f < NF; f++) begin
            weights[(f*3)*ACT +: ACT] = 8'd2;
            biases[f*ACT +: ACT] = ACT'(f * 3);
        end
        load_params();
        for (int i = 0; i < 7; i++) begin
            seq[i] = sample_t'(i * 11 + 7);
        end
        run_and_check("back_to_back", 7);
        report_test("back_to_back", errs);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        i_sample_valid = 1'b0;
        i_sample = '0;
        i_sample_last = 1'b0;
        i_load_weights = 1'b0;
        i_weights = '0;
        i_load_biases = 1'b0;
        i_biases = '0;
        i_feat_credit = 1'b0;
        weights = '0;
        biases = '0;
        slow_sink = 1'b0;
        sample_credits = CREDITS;
        errors = 0;
        timeouts = 0;
        tests_run = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        test_zero_weights();
        if (timeouts == 0) test_identity_ramp();
        if (timeouts == 0) test_edge_taps();
        if (timeouts == 0) test_relu_saturation();
        if (timeouts == 0) test_slow_sink();
        if (timeouts == 0) test_back_to_back();

        $display("Tests run: %0d, errors: %0d, timeouts: %0d", tests_run, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/cnn_layer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module cnn_layer_top
    import cnn_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          i_sample_valid,
    input  wire sample_t       i_sample,
    input  wire logic          i_sample_last,
    output logic               o_sample_credit,
    input  wire logic          i_load_weights,
    input  wire weights_flat_t i_weights,
    input  wire logic          i_load_biases,
    input  wire biases_flat_t  i_biases,
    output logic               o_feat_valid,
    output feature_vec_t       o_feat,
    output logic               o_feat_last,
    input  wire logic          i_feat_credit
);

    localparam int SMP_W  = `CNN_ACT_BITS;
    localparam int FEAT_W = `CNN_NUM_FILTERS * `CNN_ACT_BITS;

    // Last flag rides in the top bit of each FIFO entry
    logic              smp_rd_valid;
    logic [SMP_W:0]    smp_rd_data;
    logic              smp_pop;
    weights_flat_t     weights;
    biases_flat_t      biases;
    logic              feat_rd_valid;
    logic [FEAT_W:0]   feat_rd_data;
    logic              feat_pop;

    feature_link_if feat_link ();

    credit_fifo #(
        .WIDTH(SMP_W + 1)
    ) u_sample_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr_valid (i_sample_valid),
        .i_wr_data  ({i_sample_last, i_sample}),
        .i_rd_pop   (smp_pop),
        .o_rd_valid (smp_rd_valid),
        .o_rd_data  (smp_rd_data),
        .o_credit   (o_sample_credit)
    );

    kernel_store u_kernel_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_load_weights (i_load_weights),
        .i_weights      (i_weights),
        .i_load_biases  (i_load_biases),
        .i_biases       (i_biases),
        .o_weights      (weights),
        .o_biases       (biases)
    );

    conv1d_relu u_conv (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_in_valid  (smp_rd_valid),
        .i_in_sample (smp_rd_data[SMP_W-1:0]),
        .i_in_last   (smp_rd_data[SMP_W]),
        .o_in_pop    (smp_pop),
        .i_weights   (weights),
        .i_biases    (biases),
        .feat_link   (feat_link.sender)
    );

    credit_fifo #(
        .WIDTH(FEAT_W + 1)
    ) u_feat_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr_valid (feat_link.valid),
        .i_wr_data  ({feat_link.last, feat_link.data}),
        .i_rd_pop   (feat_pop),
        .o_rd_valid (feat_rd_valid),
        .o_rd_data  (feat_rd_data),
        .o_credit   (feat_link.credit)
    );

    max_pool_pair u_pool (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_in_valid   (feat_rd_valid),
        .i_in_data    (feat_rd_data[FEAT_W-1:0]),
        .i_in_last    (feat_rd_data[FEAT_W]),
        .o_in_pop     (feat_pop),
        .i_out_credit (i_feat_credit),
        .o_out_valid  (o_feat_valid),
        .o_out_data   (o_feat),
        .o_out_last   (o_feat_last)
    );

endmodule

`default_nettype wire

// ==== rtl/max_pool_pair.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module max_pool_pair
    import cnn_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         i_in_valid,
    input  wire feature_vec_t i_in_data,
    input  wire logic         i_in_last,
    output logic              o_in_pop,
    input  wire logic         i_out_credit,
    output logic              o_out_valid,
    output feature_vec_t      o_out_data,
    output logic              o_out_last
);

    localparam int ACT = `CNN_ACT_BITS;
    localparam int NF  = `CNN_NUM_FILTERS;

    // First vector of the current pair
    feature_vec_t held;
    logic         held_valid;
    feature_vec_t pair_max;
    credit_cnt_t  credits;
    logic         has_credit;
    logic         pop;
    logic         emit;

    function automatic feature_t feat_max(input feature_t a, input feature_t b);
        return (a > b) ? a : b;
    endfunction

    assign has_credit = (credits != '0);
    assign pop        = i_in_valid && has_credit;
    // Second of a pair, or a lone final position
    assign emit       = pop && (held_valid || i_in_last);
    assign o_in_pop   = pop;

    always_comb begin
        for (int f = 0; f < NF; f++) begin
            pair_max[f*ACT +: ACT] = feat_max(held[f*ACT +: ACT], i_in_data[f*ACT +: ACT]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (pop) begin
            held_valid <= !held_valid && !i_in_last;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && !held_valid) begin
            held <= i_in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_cnt_t'(`CNN_LINK_CREDITS);
        end else begin
            case ({emit, i_out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_out_valid <= 1'b0;
            o_out_last  <= 1'b0;
        end else begin
            o_out_valid <= emit;
            if (emit) begin
                o_out_last <= i_in_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            o_out_data <= held_valid ? pair_max : i_in_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/conv1d_relu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module conv1d_relu
    import cnn_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          i_in_valid,
    input  wire sample_t       i_in_sample,
    input  wire logic          i_in_last,
    output logic               o_in_pop,
    input  wire weights_flat_t i_weights,
    input  wire biases_flat_t  i_biases,
    feature_link_if.sender     feat_link
);

    localparam int ACT  = `CNN_ACT_BITS;
    localparam int NF   = `CNN_NUM_FILTERS;
    localparam int TAPS = `CNN_TAPS;

    localparam acc_t ACT_MAX = acc_t'((1 << ACT) - 1);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FLUSH
    } conv_state_e;

    conv_state_e  state;
    sample_t      win_left;
    sample_t      win_cur;
    // Left slot holds a sample of the current sequence
    logic         win_in_seq;
    credit_cnt_t  credits;
    logic         has_credit;
    logic         pop;
    logic         emit;
    sample_t      taps [TAPS];
    acc_t         acc [NF];
    feature_vec_t feat_next;

    function automatic acc_t tap_term(input weight_t w, input sample_t x);
        acc_t xs;
        xs = acc_t'({1'b0, x});
        return acc_t'(w) * xs;
    endfunction

    function automatic feature_t relu_sat(input acc_t sum);
        if (sum < 0) begin
            return '0;
        end
        if (sum > ACT_MAX) begin
            return '1;
        end
        return feature_t'(sum);
    endfunction

    assign has_credit = (credits != '0);
    assign pop        = (state != FLUSH) && i_in_valid && has_credit;
    assign emit       = ((state == RUN) && pop) || ((state == FLUSH) && has_credit);
    assign o_in_pop   = pop;

    // Zero padding at both ends of the sequence
    always_comb begin
        taps[0] = win_in_seq ? win_left : '0;
        taps[1] = win_cur;
        taps[2] = (state == FLUSH) ? '0 : i_in_sample;
    end

    always_comb begin
        for (int f = 0; f < NF; f++) begin
            acc[f] = acc_t'(weight_t'(i_biases[f*ACT +: ACT]));
            for (int t = 0; t < TAPS; t++) begin
                acc[f] = acc[f] + tap_term(weight_t'(i_weights[(f*TAPS+t)*ACT +: ACT]),
                                           taps[t]);
            end
            feat_next[f*ACT +: ACT] = relu_sat(acc[f]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        state <= i_in_last ? FLUSH : RUN;
                    end
                end
                RUN: begin
                    if (pop && i_in_last) begin
                        state <= FLUSH;
                    end
                end
                FLUSH: begin
                    if (has_credit) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            win_left <= win_cur;
            win_cur  <= i_in_sample;
        end
    end

    // First sample of a sequence leaves the left slot empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_in_seq <= 1'b0;
        end else if (pop) begin
            win_in_seq <= (state == RUN);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_cnt_t'(`CNN_LINK_CREDITS);
        end else begin
            case ({emit, feat_link.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feat_link.valid <= 1'b0;
            feat_link.last  <= 1'b0;
        end else begin
            feat_link.valid <= emit;
            if (emit) begin
                feat_link.last <= (state == FLUSH);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            feat_link.data <= feat_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/kernel_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module kernel_store
    import cnn_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          i_load_weights,
    input  wire weights_flat_t i_weights,
    input  wire logic          i_load_biases,
    input  wire biases_flat_t  i_biases,
    output weights_flat_t      o_weights,
    output biases_flat_t       o_biases
);

    // Weights and biases load on separate strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_weights <= '0;
        end else if (i_load_weights) begin
            o_weights <= i_weights;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_biases <= '0;
        end else if (i_load_biases) begin
            o_biases <= i_biases;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module credit_fifo
    import cnn_pkg::*;
#(
    parameter int WIDTH = 9
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             i_wr_valid,
    input  wire logic [WIDTH-1:0] i_wr_data,
    input  wire logic             i_rd_pop,
    output logic                  o_rd_valid,
    output logic [WIDTH-1:0]      o_rd_data,
    output logic                  o_credit
);

    localparam int DEPTH    = `CNN_LINK_CREDITS;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_BITS-1:0] ptr_t;

    logic [WIDTH-1:0] mem [DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    credit_cnt_t      count;
    logic             do_pop;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Pop of an empty buffer is ignored
    assign do_pop     = i_rd_pop && (count != '0);
    assign o_rd_valid = (count != '0);
    assign o_rd_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_wr_valid) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({i_wr_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Freed entry goes back to the sender
            o_credit <= do_pop;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/feature_link_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

interface feature_link_if
    import cnn_pkg::*;
();

    logic         valid;
    feature_vec_t data;
    logic         last;
    // One pulse per freed receiver entry
    logic         credit;

    modport sender (
        output valid,
        output data,
        output last,
        input  credit
    );

    modport receiver (
        input  valid,
        input  data,
        input  last,
        output credit
    );

endinterface

`default_nettype wire

// ==== rtl/cnn_pkg.sv ====
`default_nettype none

`include "cnn_consts.svh"

package cnn_pkg;

    // Unsigned input sample
    typedef logic [`CNN_ACT_BITS-1:0] sample_t;

    // Signed weight or bias
    typedef logic signed [`CNN_ACT_BITS-1:0] weight_t;

    typedef logic signed [`CNN_ACC_BITS-1:0] acc_t;

    // Unsigned activation after ReLU
    typedef logic [`CNN_ACT_BITS-1:0] feature_t;

    // One feature per filter, filter 0 in the low byte
    typedef logic [`CNN_NUM_FILTERS*`CNN_ACT_BITS-1:0] feature_vec_t;

    // Byte index is filter * taps + tap
    typedef logic [`CNN_NUM_FILTERS*`CNN_TAPS*`CNN_ACT_BITS-1:0] weights_flat_t;

    typedef logic [`CNN_NUM_FILTERS*`CNN_ACT_BITS-1:0] biases_flat_t;

    // Holds 0 up to the full credit count
    typedef logic [$clog2(`CNN_LINK_CREDITS+1)-1:0] credit_cnt_t;

endpackage

`default_nettype wire

// ==== rtl/cnn_consts.svh ====
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// Sample, weight, bias and feature width
`define CNN_ACT_BITS 8

// Signed accumulator width
`define CNN_ACC_BITS 20

`define CNN_NUM_FILTERS 8

// Kernel taps, left neighbour first
`define CNN_TAPS 3

// Credits per link, equal to the receiving FIFO depth
`define CNN_LINK_CREDITS 4

`endif
